// ==== bench/dcache_assert.sv ====
module dcache_assert (
    input logic                     CLK,
    input logic                     nRST,
    input logic                     dwait,
    input dcache_bus_pkg::mem_req_t mem_req,
    input logic                     halted,
    input logic                     flushed
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // one transfer direction at a time
    one_direction: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else begin
            fail_count++;
            $error("memory read and write requested together");
        end

    flushed_halted: assert property (@(posedge CLK) disable iff (!nRST)
        flushed |-> halted)
        else begin
            fail_count++;
            $error("flushed is high while halted is low");
        end

    flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
        flushed |=> flushed)
        else begin
            fail_count++;
            $error("flushed dropped before reset");
        end

    // memory side holds while the transfer waits
    hold_on_wait: assert property (@(posedge CLK) disable iff (!nRST)
        ((mem_req.ren || mem_req.wen) && dwait) |=> $stable(mem_req))
        else begin
            fail_count++;
            $error("mem_req changed while dwait was high");
        end

endmodule

bind dcache dcache_assert i_assert (
    .CLK     (CLK),
    .nRST    (nRST),
    .dwait   (dwait),
    .mem_req (mem_req),
    .halted  (halted),
    .flushed (flushed)
);

// ==== bench/tb_dcache.sv ====
module tb_dcache;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_HALT
    } op_t;

    // expected values come from the shadow at table build time
    typedef struct packed {
        op_t                     op;
        dcache_types_pkg::word_t addr;
        dcache_types_pkg::word_t data;
        dcache_types_pkg::word_t exp_load;
        logic [7:0]              n_rd;
        logic [7:0]              n_wr;
        dcache_types_pkg::word_t wb_blk;
        dcache_types_pkg::word_t wb_one;
        dcache_types_pkg::word_t wb_two;
    } entry_t;

    logic                     CLK;
    logic                     nRST;
    dcache_bus_pkg::dp_req_t  dp_req;
    logic                     dwait;
    dcache_types_pkg::word_t  dload;
    dcache_bus_pkg::dp_rsp_t  dp_rsp;
    dcache_bus_pkg::mem_req_t mem_req;
    logic                     halted;
    logic                     flushed;

    dcache_types_pkg::word_t mem [dcache_types_pkg::word_t];
    dcache_types_pkg::word_t shadow [dcache_types_pkg::word_t];
    dcache_types_pkg::word_t rd_log [$];
    dcache_types_pkg::word_t wr_addr_log [$];
    dcache_types_pkg::word_t wr_data_log [$];
    entry_t                  tests [$];
    logic                    table_ready;
    int                      checks;
    int                      errors;

    dcache i_dut (
        .CLK     (CLK),
        .nRST    (nRST),
        .dp_req  (dp_req),
        .dwait   (dwait),
        .dload   (dload),
        .dp_rsp  (dp_rsp),
        .mem_req (mem_req),
        .halted  (halted),
        .flushed (flushed)
    );

    always #5 CLK = ~CLK;

    function automatic dcache_types_pkg::word_t fill_word(input dcache_types_pkg::word_t a);
        return a ^ 32'hA5A5_0000;
    endfunction

    function automatic dcache_types_pkg::word_t mem_word(input dcache_types_pkg::word_t a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    function automatic dcache_types_pkg::word_t shadow_word(input dcache_types_pkg::word_t a);
        return shadow.exists(a) ? shadow[a] : fill_word(a);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // n_wr on a read or write means an eviction of wb_blk
    task automatic add_entry(input op_t op, input dcache_types_pkg::word_t addr,
                             input dcache_types_pkg::word_t data, input int n_rd,
                             input int n_wr, input dcache_types_pkg::word_t wb_blk);
        entry_t e;
        e          = '0;
        e.op       = op;
        e.addr     = addr;
        e.data     = data;
        e.n_rd     = 8'(n_rd);
        e.n_wr     = 8'(n_wr);
        e.wb_blk   = wb_blk;
        e.wb_one   = shadow_word(wb_blk);
        e.wb_two   = shadow_word(wb_blk + 32'h4);
        e.exp_load = shadow_word(addr);
        if (op == OP_WRITE) begin
            shadow[addr] = data;
        end
        tests.push_back(e);
    endtask

    task automatic build_table();
        add_entry(OP_READ,  32'h0000_0100, '0,            2, 0,  '0);
        add_entry(OP_READ,  32'h0000_0104, '0,            0, 0,  '0);
        add_entry(OP_WRITE, 32'h0000_0148, 32'hDEAD_0001, 2, 0,  '0);
        add_entry(OP_READ,  32'h0000_0148, '0,            0, 0,  '0);
        // three tags in set 2 with the first one dirty
        add_entry(OP_WRITE, 32'h0000_0214, 32'hBEEF_0002, 2, 0,  '0);
        add_entry(OP_READ,  32'h0000_0250, '0,            2, 0,  '0);
        add_entry(OP_READ,  32'h0000_0290, '0,            2, 2,  32'h0000_0210);
        add_entry(OP_READ,  32'h0000_0214, '0,            2, 0,  '0);
        add_entry(OP_WRITE, 32'h0000_0290, 32'h0C0C_0003, 0, 0,  '0);
        add_entry(OP_WRITE, 32'h0000_0210, 32'h0A0A_0004, 0, 0,  '0);
        add_entry(OP_WRITE, 32'h0000_03F8, 32'h7777_0005, 2, 0,  '0);
        add_entry(OP_WRITE, 32'h0000_043C, 32'h7777_0006, 2, 0,  '0);
        add_entry(OP_READ,  32'h0000_043C, '0,            0, 0,  '0);
        add_entry(OP_WRITE, 32'h0000_0104, 32'h1111_0007, 0, 0,  '0);
        add_entry(OP_READ,  32'h0000_03F8, '0,            0, 0,  '0);
        // six dirty frames of two words each
        add_entry(OP_HALT,  '0,            '0,            0, 12, '0);
    endtask

    task automatic run_entry(input entry_t e);
        dcache_bus_pkg::dp_req_t req;
        dcache_types_pkg::word_t base;
        req       = '0;
        req.ren   = (e.op == OP_READ);
        req.wen   = (e.op == OP_WRITE);
        req.halt  = (e.op == OP_HALT);
        req.addr  = e.addr;
        req.store = e.data;
        base      = e.addr & 32'hFFFF_FFF8;
        @(negedge CLK);
        rd_log.delete();
        wr_addr_log.delete();
        wr_data_log.delete();
        dp_req = req;
        if (e.op == OP_HALT) begin
            do begin
                @(negedge CLK);
            end while (!flushed);
            check_value("halted", 32'(halted), 32'h1);
        end else begin
            do begin
                @(negedge CLK);
            end while (!dp_rsp.hit);
            if (e.op == OP_READ) begin
                check_value("dp_rsp.load", dp_rsp.load, e.exp_load);
            end
        end
        check_value("memory read count", rd_log.size(), 32'(e.n_rd));
        if (e.n_rd == 2 && rd_log.size() == 2) begin
            check_value("mem_req.addr (fetch one)", rd_log[0], base);
            check_value("mem_req.addr (fetch two)", rd_log[1], base + 32'h4);
        end
        check_value("memory write count", wr_addr_log.size(), 32'(e.n_wr));
        if (e.op != OP_HALT && e.n_wr == 2 && wr_addr_log.size() == 2) begin
            check_value("mem_req.addr (write-back one)", wr_addr_log[0], e.wb_blk);
            check_value("mem_req.store (write-back one)", wr_data_log[0], e.wb_one);
            check_value("mem_req.addr (write-back two)", wr_addr_log[1], e.wb_blk + 32'h4);
            check_value("mem_req.store (write-back two)", wr_data_log[1], e.wb_two);
        end
    endtask

    task automatic check_memory();
        foreach (shadow[a]) begin
            check_value($sformatf("memory word 0x%h", a), mem_word(a), shadow[a]);
        end
    endtask

    // memory model with 0 to 3 random wait cycles per word
    initial begin
        int unsigned delay;
        bit          pending;
        delay   = 0;
        pending = 1'b0;
        dwait   = 1'b1;
        dload   = '0;
        void'($urandom(59));
        forever begin
            @(negedge CLK);
            if (!nRST || !(mem_req.ren || mem_req.wen)) begin
                dwait   = 1'b1;
                pending = 1'b0;
            end else begin
                if (!pending) begin
                    pending = 1'b1;
                    delay   = $urandom_range(3, 0);
                end
                if (delay != 0) begin
                    dwait = 1'b1;
                    delay--;
                end else begin
                    dwait   = 1'b0;
                    pending = 1'b0;
                    if (mem_req.ren) begin
                        dload = mem_word(mem_req.addr);
                        rd_log.push_back(mem_req.addr);
                    end else begin
                        mem[mem_req.addr] = mem_req.store;
                        wr_addr_log.push_back(mem_req.addr);
                        wr_data_log.push_back(mem_req.store);
                    end
                end
            end
        end
    end

    initial begin
        int limit;
        wait (table_ready === 1'b1);
        limit = tests.size() * 200;
        repeat (limit) @(posedge CLK);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int assert_fails;
        CLK         = 1'b0;
        nRST        = 1'b0;
        dp_req      = '0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);
        // idle outputs before the first request
        check_value("dp_rsp.hit", 32'(dp_rsp.hit), 32'h0);
        check_value("mem_req.ren", 32'(mem_req.ren), 32'h0);
        check_value("mem_req.wen", 32'(mem_req.wen), 32'h0);
        check_value("halted", 32'(halted), 32'h0);
        check_value("flushed", 32'(flushed), 32'h0);
        foreach (tests[i]) begin
            run_entry(tests[i]);
        end
        check_memory();
        @(negedge CLK);
        assert_fails = i_dut.i_assert.fail_count;
        $display("checks: %0d, check errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
source/dcache_types_pkg.sv
source/dcache_bus_pkg.sv
source/dcache_array.sv
source/dcache_ctrl.sv
source/dcache.sv
bench/dcache_assert.sv
bench/tb_dcache.sv

// ==== include/dcache_cfg.svh ====
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// word and address width
`define DCACHE_WORD_W 32

// set geometry
`define DCACHE_SETS 8
`define DCACHE_IDX_W 3

// address fields
`define DCACHE_TAG_W 26
`define DCACHE_BYTOFF_W 2

// two ways x two words x all sets
`define DCACHE_FLUSH_SLOTS 32

`endif

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_dcache -Mdir obj_dir -o sim_dcache -f build.f \
    && ./obj_dir/sim_dcache +verilator+error+limit+1000 2>&1 | tee sim.log
grep -q "TESTS PASSED" sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

// ==== source/dcache.sv ====
module dcache (
    input  logic                     CLK,
    input  logic                     nRST,
    input  dcache_bus_pkg::dp_req_t  dp_req,
    input  logic                     dwait,
    input  dcache_types_pkg::word_t  dload,
    output dcache_bus_pkg::dp_rsp_t  dp_rsp,
    output dcache_bus_pkg::mem_req_t mem_req,
    output logic                     halted,
    output logic                     flushed
);

    dcache_types_pkg::dcache_addr_t lookup;
    dcache_types_pkg::array_wr_t    wr;
    dcache_types_pkg::set_view_t    view;

    dcache_array i_array (
        .CLK    (CLK),
        .nRST   (nRST),
        .lookup (lookup),
        .wr     (wr),
        .view   (view)
    );

    dcache_ctrl i_ctrl (
        .CLK     (CLK),
        .nRST    (nRST),
        .dp_req  (dp_req),
        .dwait   (dwait),
        .dload   (dload),
        .view    (view),
        .lookup  (lookup),
        .wr      (wr),
        .dp_rsp  (dp_rsp),
        .mem_req (mem_req),
        .halted  (halted),
        .flushed (flushed)
    );

endmodule

// ==== source/dcache_array.sv ====
`include "dcache_cfg.svh"

module dcache_array (
    input  logic                           CLK,
    input  logic                           nRST,
    input  dcache_types_pkg::dcache_addr_t lookup,
    input  dcache_types_pkg::array_wr_t    wr,
    output dcache_types_pkg::set_view_t    view
);

    // frames[0] is way one, frames[1] is way two
    dcache_types_pkg::frame_t frames [2][`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0]  lru;

    dcache_types_pkg::frame_t cur_one;
    dcache_types_pkg::frame_t cur_two;

    always_comb begin
        cur_one = frames[0][lookup.idx];
        cur_two = frames[1][lookup.idx];
    end

    // tag compare for both ways of the looked-up set
    always_comb begin
        view.frame_one = cur_one;
        view.frame_two = cur_two;
        view.hit_one   = cur_one.valid && (cur_one.tag == lookup.tag);
        view.hit_two   = cur_two.valid && (cur_two.tag == lookup.tag);
        view.lru       = lru[lookup.idx];
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < `DCACHE_SETS; s++) begin
                    frames[w][s] <= '0;
                end
            end
        end else if (wr.we) begin
            if (wr.fill) begin
                frames[wr.way][wr.idx] <= wr.frame;
            end else begin
                // single word store marks the frame dirty
                if (wr.blkoff) begin
                    frames[wr.way][wr.idx].data_two <= wr.data;
                end else begin
                    frames[wr.way][wr.idx].data_one <= wr.data;
                end
                frames[wr.way][wr.idx].dirty <= 1'b1;
            end
        end
    end

    // point at the way not just used
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lru <= '0;
        end else if (wr.touch) begin
            lru[wr.idx] <= ~wr.way;
        end
    end

endmodule

// ==== source/dcache_bus_pkg.sv ====
package dcache_bus_pkg;

    // datapath side
    typedef struct packed {
        logic                    ren;
        logic                    wen;
        logic                    halt;
        dcache_types_pkg::word_t addr;
        dcache_types_pkg::word_t store;
    } dp_req_t;

    typedef struct packed {
        logic                    hit;
        dcache_types_pkg::word_t load;
    } dp_rsp_t;

    // memory side moves one word per transfer
    typedef struct packed {
        logic                    ren;
        logic                    wen;
        dcache_types_pkg::word_t addr;
        dcache_types_pkg::word_t store;
    } mem_req_t;

endpackage

// ==== source/dcache_ctrl.sv ====
`include "dcache_cfg.svh"

module dcache_ctrl (
    input  logic                           CLK,
    input  logic                           nRST,
    input  dcache_bus_pkg::dp_req_t        dp_req,
    input  logic                           dwait,
    input  dcache_types_pkg::word_t        dload,
    input  dcache_types_pkg::set_view_t    view,
    output dcache_types_pkg::dcache_addr_t lookup,
    output dcache_types_pkg::array_wr_t    wr,
    output dcache_bus_pkg::dp_rsp_t        dp_rsp,
    output dcache_bus_pkg::mem_req_t       mem_req,
    output logic                           halted,
    output logic                           flushed
);

    localparam int SLOT_W = $clog2(`DCACHE_FLUSH_SLOTS);

    typedef enum logic [2:0] {
        IDLE, WRITE, WB_ONE, WB_TWO, FETCH_ONE, FETCH_TWO, FLUSH, DONE
    } state_t;

    state_t                   state, next_state;
    dcache_types_pkg::word_t  first_word;
    logic [SLOT_W-1:0]        slot;
    logic                     slot_adv;

    dcache_types_pkg::dcache_addr_t req_addr;
    dcache_types_pkg::frame_t       hit_frame;
    dcache_types_pkg::frame_t       vic_frame;
    dcache_types_pkg::frame_t       slot_frame;
    dcache_types_pkg::word_t        slot_word;
    logic                           hit;

    assign req_addr = dcache_types_pkg::dcache_addr_t'(dp_req.addr);
    assign hit      = view.hit_one || view.hit_two;

    // slot bits are way, word and set from the top
    always_comb begin
        lookup = req_addr;
        if (state == FLUSH) begin
            lookup.idx = slot[`DCACHE_IDX_W-1:0];
        end
    end

    always_comb begin
        hit_frame  = view.hit_two ? view.frame_two : view.frame_one;
        vic_frame  = view.lru ? view.frame_two : view.frame_one;
        slot_frame = slot[`DCACHE_IDX_W+1] ? view.frame_two : view.frame_one;
        slot_word  = slot[`DCACHE_IDX_W] ? slot_frame.data_two : slot_frame.data_one;
    end

    assign halted      = (state == FLUSH) || (state == DONE);
    assign flushed     = (state == DONE);

    always_comb begin
        next_state  = state;
        dp_rsp.hit  = 1'b0;
        dp_rsp.load = req_addr.blkoff ? hit_frame.data_two : hit_frame.data_one;
        mem_req     = '0;
        slot_adv    = 1'b0;
        wr          = '0;
        wr.idx      = lookup.idx;
        wr.blkoff   = req_addr.blkoff;
        wr.data     = dp_req.store;
        wr.way      = view.hit_two;

        case (state)
            IDLE: begin
                if (dp_req.halt) begin
                    next_state = FLUSH;
                end else if (dp_req.ren || dp_req.wen) begin
                    if (!hit) begin
                        next_state = (vic_frame.valid && vic_frame.dirty) ? WB_ONE : FETCH_ONE;
                    end else if (dp_req.wen) begin
                        next_state = WRITE;
                    end else begin
                        dp_rsp.hit = 1'b1;
                        wr.touch   = 1'b1;
                    end
                end
            end
            WRITE: begin
                wr.we      = 1'b1;
                wr.touch   = 1'b1;
                dp_rsp.hit = 1'b1;
                next_state = IDLE;
            end
            WB_ONE, WB_TWO: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = {vic_frame.tag, req_addr.idx, state == WB_TWO,
                                 {`DCACHE_BYTOFF_W{1'b0}}};
                mem_req.store = (state == WB_TWO) ? vic_frame.data_two : vic_frame.data_one;
                if (!dwait) begin
                    next_state = (state == WB_TWO) ? FETCH_ONE : WB_TWO;
                end
            end
            FETCH_ONE, FETCH_TWO: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = {req_addr.tag, req_addr.idx, state == FETCH_TWO,
                                {`DCACHE_BYTOFF_W{1'b0}}};
                if (!dwait) begin
                    next_state = (state == FETCH_TWO) ? IDLE : FETCH_TWO;
                end
                // install clean block into the victim way
                if (state == FETCH_TWO && !dwait) begin
                    wr.we             = 1'b1;
                    wr.fill           = 1'b1;
                    wr.touch          = 1'b1;
                    wr.way            = view.lru;
                    wr.frame.data_one = first_word;
                    wr.frame.data_two = dload;
                    wr.frame.tag      = req_addr.tag;
                    wr.frame.valid    = 1'b1;
                end
            end
            FLUSH: begin
                if (slot_frame.valid && slot_frame.dirty) begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = {slot_frame.tag, slot[`DCACHE_IDX_W-1:0],
                                     slot[`DCACHE_IDX_W], {`DCACHE_BYTOFF_W{1'b0}}};
                    mem_req.store = slot_word;
                    slot_adv      = !dwait;
                end else begin
                    slot_adv = 1'b1;
                end
                if (slot_adv && slot == SLOT_W'(`DCACHE_FLUSH_SLOTS - 1)) begin
                    next_state = DONE;
                end
            end
            default: begin
                next_state = DONE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            slot  <= '0;
        end else begin
            state <= next_state;
            if (slot_adv) begin
                slot <= slot + 1'b1;
            end
        end
    end

    // first word of the block held until FETCH_TWO
    always_ff @(posedge CLK) begin
        if (state == FETCH_ONE && !dwait) begin
            first_word <= dload;
        end
    end

endmodule

// ==== source/dcache_types_pkg.sv ====
`include "dcache_cfg.svh"

package dcache_types_pkg;

    typedef logic [`DCACHE_WORD_W-1:0] word_t;

    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0]    tag;
        logic [`DCACHE_IDX_W-1:0]    idx;
        logic                        blkoff;
        logic [`DCACHE_BYTOFF_W-1:0] bytoff;
    } dcache_addr_t;

    typedef struct packed {
        word_t                    data_one;
        word_t                    data_two;
        logic [`DCACHE_TAG_W-1:0] tag;
        logic                     dirty;
        logic                     valid;
    } frame_t;

    // lru = 0 replaces way one next
    typedef struct packed {
        frame_t frame_one;
        frame_t frame_two;
        logic   hit_one;
        logic   hit_two;
        logic   lru;
    } set_view_t;

    typedef struct packed {
        logic                     we;
        logic                     way;
        logic [`DCACHE_IDX_W-1:0] idx;
        logic                     fill;
        frame_t                   frame;
        logic                     blkoff;
        word_t                    data;
        logic                     touch;
    } array_wr_t;

endpackage
